// File: src/bram_chain_cfg_pkg.sv
/*
 * Memory bank chain configuration
 * Word and address sizes, bank count and write-back delay defaults
 */
`default_nettype none

package bram_chain_cfg_pkg;

    // ====================
    // Storage geometry
    // ====================

    // Width of one stored word
    localparam int DATA_W = 12;

    // Bank address width
    localparam int ADDR_W = 5;

    // Entries per bank
    localparam int BANK_DEPTH = 2 ** ADDR_W;

    // ====================
    // Chain defaults
    // ====================

    // Banks in the chain, each one feeds two lanes
    localparam int NUM_BANKS_DEF = 8;

    // Chain strobes between a read and the write-back that reuses its address
    // Matches the datapath pipeline depth
    localparam int WB_DELAY_DEF = 7;

endpackage : bram_chain_cfg_pkg

`default_nettype wire

// File: src/bram_chain_types_pkg.sv
/*
 * Memory bank chain types
 * Word, address and controller mode types shared by the chain
 */
`default_nettype none

package bram_chain_types_pkg;

    // One stored word as seen on every lane
    typedef logic [bram_chain_cfg_pkg::DATA_W-1:0] data_word_t;

    // One bank address
    typedef logic [bram_chain_cfg_pkg::ADDR_W-1:0] addr_word_t;

    // ====================
    // Controller modes
    // ====================

    // Idle holds addresses and parks din at zero
    // Load broadcasts controller words to every bank
    // Exec covers chain reads and write-back
    typedef enum logic [1:0] {
        MODE_IDLE = 2'b00,
        MODE_LOAD = 2'b01,
        MODE_EXEC = 2'b10
    } bank_mode_e;

endpackage : bram_chain_types_pkg

`default_nettype wire

// File: src/bank_port_if.sv
/*
 * Bank port bundle
 * Both ports of one dual-port bank between the controller and the memory
 */
`timescale 1ns/1ns
`default_nettype none

interface bank_port_if;

    // Shared write enable for ports A and B
    logic we;

    // Separate read and write addresses per port
    bram_chain_types_pkg::addr_word_t raddr_a;
    bram_chain_types_pkg::addr_word_t raddr_b;
    bram_chain_types_pkg::addr_word_t waddr_a;
    bram_chain_types_pkg::addr_word_t waddr_b;

    // Write data into the bank
    bram_chain_types_pkg::data_word_t din_a;
    bram_chain_types_pkg::data_word_t din_b;

    // Registered read data out of the bank
    bram_chain_types_pkg::data_word_t dout_a;
    bram_chain_types_pkg::data_word_t dout_b;

    // Controller side
    modport ctrl (
        output we,
        output raddr_a, raddr_b, waddr_a, waddr_b,
        output din_a, din_b
    );

    // Memory side
    modport mem (
        input  we,
        input  raddr_a, raddr_b, waddr_a, waddr_b,
        input  din_a, din_b,
        output dout_a, dout_b
    );

endinterface : bank_port_if

`default_nettype wire

// File: src/bram_tdp.sv
/*
 * True dual-port memory bank
 * Two write ports and two registered read-first read ports
 * Read and write addresses are separate on each port
 */
`timescale 1ns/1ns
`default_nettype none

module bram_tdp (
    input  wire logic   clk_i,
    input  wire logic   rst_i,
    bank_port_if.mem    port
);

    // Storage array
    bram_chain_types_pkg::data_word_t mem_q [bram_chain_cfg_pkg::BANK_DEPTH];

    // Power-up contents are all zero
    initial begin
        for (int i = 0; i < bram_chain_cfg_pkg::BANK_DEPTH; i++) begin
            mem_q[i] = '0;
        end
    end

    // ====================
    // Write ports
    // ====================

    // A first, then B
    // B overrides A when both hit one address
    always_ff @(posedge clk_i) begin
        if (port.we) begin
            mem_q[port.waddr_a] <= port.din_a;
            mem_q[port.waddr_b] <= port.din_b;
        end
    end

    // ====================
    // Read ports
    // ====================

    // Nonblocking read sees the word before any same-edge write
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            port.dout_a <= '0;
            port.dout_b <= '0;
        end else begin
            port.dout_a <= mem_q[port.raddr_a];
            port.dout_b <= mem_q[port.raddr_b];
        end
    end

endmodule : bram_tdp

`default_nettype wire

// File: src/writeback_addr_delay.sv
/*
 * Write-back address delay line
 * Remembers each lane's read address for WB_DELAY chain strobes
 * Advances on strobes only, so idle gaps do not age the entries
 */
`timescale 1ns/1ns
`default_nettype none

module writeback_addr_delay #(
    parameter int NUM_BANKS = 8,
    parameter int WB_DELAY  = 7
) (
    input  wire logic                                           clk_i,
    input  wire logic                                           rst_i,
    input  wire logic                                           shift_i,
    input  wire bram_chain_types_pkg::addr_word_t [2*NUM_BANKS-1:0] rd_addr_i,
    output bram_chain_types_pkg::addr_word_t [2*NUM_BANKS-1:0]      wb_addr_o
);

    // Two lanes per bank
    localparam int LANES = 2 * NUM_BANKS;

    // Stage 0 holds the newest read, stage WB_DELAY-1 the oldest
    bram_chain_types_pkg::addr_word_t [LANES-1:0] stage_q [WB_DELAY];

    // ====================
    // Shift register
    // ====================

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < WB_DELAY; i++) begin
                stage_q[i] <= '0;
            end
        end else if (shift_i) begin
            // All lanes move together
            stage_q[0] <= rd_addr_i;
            for (int i = 1; i < WB_DELAY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Oldest stage feeds the write-back address
    assign wb_addr_o = stage_q[WB_DELAY-1];

endmodule : writeback_addr_delay

`default_nettype wire

// File: src/bank_port_ctrl.sv
/*
 * Bank port controller
 * Decodes load, chain and write strobes into a mode and registers
 * every bank's read address, write address and write data
 */
`timescale 1ns/1ns
`default_nettype none

module bank_port_ctrl #(
    parameter int NUM_BANKS = 8
) (
    input  wire logic                                                clk_i,
    input  wire logic                                                rst_i,
    input  wire logic                                                load_en_i,
    input  wire logic                                                chain_en_i,
    input  wire logic                                                write_en_i,
    input  wire logic [NUM_BANKS-1:0]                                bank_we_i,
    input  wire bram_chain_types_pkg::data_word_t                    load_data_a_i,
    input  wire bram_chain_types_pkg::data_word_t                    load_data_b_i,
    input  wire bram_chain_types_pkg::addr_word_t                    load_addr_a_i,
    input  wire bram_chain_types_pkg::addr_word_t                    load_addr_b_i,
    input  wire bram_chain_types_pkg::addr_word_t [2*NUM_BANKS-1:0]  gen_addr_i,
    input  wire bram_chain_types_pkg::addr_word_t [2*NUM_BANKS-1:0]  wb_addr_i,
    input  wire bram_chain_types_pkg::data_word_t [2*NUM_BANKS-1:0]  wb_data_i,
    bank_port_if.ctrl                                                banks [NUM_BANKS]
);

    // ====================
    // Mode decode
    // ====================

    bram_chain_types_pkg::bank_mode_e mode;

    // Load wins over chain and write
    always_comb begin
        if (load_en_i) begin
            mode = bram_chain_types_pkg::MODE_LOAD;
        end else if (chain_en_i || write_en_i) begin
            mode = bram_chain_types_pkg::MODE_EXEC;
        end else begin
            mode = bram_chain_types_pkg::MODE_IDLE;
        end
    end

    // ====================
    // Per-bank registers
    // ====================

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        bram_chain_types_pkg::addr_word_t raddr_a_q;
        bram_chain_types_pkg::addr_word_t raddr_b_q;
        bram_chain_types_pkg::addr_word_t waddr_a_q;
        bram_chain_types_pkg::addr_word_t waddr_b_q;
        bram_chain_types_pkg::data_word_t din_a_q;
        bram_chain_types_pkg::data_word_t din_b_q;

        always_ff @(posedge clk_i or posedge rst_i) begin
            if (rst_i) begin
                raddr_a_q <= '0;
                raddr_b_q <= '0;
                waddr_a_q <= '0;
                waddr_b_q <= '0;
                din_a_q   <= '0;
                din_b_q   <= '0;
            end else begin
                // Data parks at zero unless a load or write drives it
                din_a_q <= '0;
                din_b_q <= '0;
                case (mode)
                    bram_chain_types_pkg::MODE_LOAD: begin
                        // Same word and address broadcast to every bank
                        raddr_a_q <= load_addr_a_i;
                        waddr_a_q <= load_addr_a_i;
                        din_a_q   <= load_data_a_i;
                        raddr_b_q <= load_addr_b_i;
                        waddr_b_q <= load_addr_b_i;
                        din_b_q   <= load_data_b_i;
                    end
                    bram_chain_types_pkg::MODE_EXEC: begin
                        // Read side from the address generator
                        if (chain_en_i) begin
                            raddr_a_q <= gen_addr_i[k];
                            raddr_b_q <= gen_addr_i[NUM_BANKS+k];
                        end
                        // Write side reuses the delayed read address
                        if (write_en_i) begin
                            waddr_a_q <= wb_addr_i[k];
                            waddr_b_q <= wb_addr_i[NUM_BANKS+k];
                            din_a_q   <= wb_data_i[k];
                            din_b_q   <= wb_data_i[NUM_BANKS+k];
                        end
                    end
                    default: begin
                        // Idle, addresses hold
                    end
                endcase
            end
        end

        // Enable goes straight through, sampled with the registered data
        assign banks[k].we      = bank_we_i[k];
        assign banks[k].raddr_a = raddr_a_q;
        assign banks[k].raddr_b = raddr_b_q;
        assign banks[k].waddr_a = waddr_a_q;
        assign banks[k].waddr_b = waddr_b_q;
        assign banks[k].din_a   = din_a_q;
        assign banks[k].din_b   = din_b_q;
    end

endmodule : bank_port_ctrl

`default_nettype wire

// File: src/bram_chain.sv
/*
 * Memory bank chain top level
 * Controller, write-back delay line and dual-port banks feeding the datapath
 * Lane k is port A of bank k, lane NUM_BANKS+k is port B
 */
`timescale 1ns/1ns
`default_nettype none

module bram_chain #(
    parameter int NUM_BANKS = bram_chain_cfg_pkg::NUM_BANKS_DEF,
    parameter int WB_DELAY  = bram_chain_cfg_pkg::WB_DELAY_DEF
) (
    input  wire logic                                                clk_i,
    input  wire logic                                                rst_i,
    input  wire logic                                                load_en_i,
    input  wire logic                                                chain_en_i,
    input  wire logic                                                write_en_i,
    input  wire logic [NUM_BANKS-1:0]                                bank_we_i,
    input  wire bram_chain_types_pkg::data_word_t                    load_data_a_i,
    input  wire bram_chain_types_pkg::data_word_t                    load_data_b_i,
    input  wire bram_chain_types_pkg::addr_word_t                    load_addr_a_i,
    input  wire bram_chain_types_pkg::addr_word_t                    load_addr_b_i,
    input  wire bram_chain_types_pkg::addr_word_t [2*NUM_BANKS-1:0]  gen_addr_i,
    input  wire bram_chain_types_pkg::data_word_t [2*NUM_BANKS-1:0]  wb_data_i,
    output bram_chain_types_pkg::data_word_t [2*NUM_BANKS-1:0]       bank_data_o
);

    // Delayed read addresses for write-back
    bram_chain_types_pkg::addr_word_t [2*NUM_BANKS-1:0] wb_addr;

    // One port bundle per bank
    bank_port_if bank_if [NUM_BANKS] ();

    // ====================
    // Control path
    // ====================

    bank_port_ctrl #(
        .NUM_BANKS (NUM_BANKS)
    ) ctrl_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .load_en_i     (load_en_i),
        .chain_en_i    (chain_en_i),
        .write_en_i    (write_en_i),
        .bank_we_i     (bank_we_i),
        .load_data_a_i (load_data_a_i),
        .load_data_b_i (load_data_b_i),
        .load_addr_a_i (load_addr_a_i),
        .load_addr_b_i (load_addr_b_i),
        .gen_addr_i    (gen_addr_i),
        .wb_addr_i     (wb_addr),
        .wb_data_i     (wb_data_i),
        .banks         (bank_if)
    );

    // Counts chain strobes, load cycles included
    writeback_addr_delay #(
        .NUM_BANKS (NUM_BANKS),
        .WB_DELAY  (WB_DELAY)
    ) wb_delay_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .shift_i   (chain_en_i),
        .rd_addr_i (gen_addr_i),
        .wb_addr_o (wb_addr)
    );

    // ====================
    // Memory banks
    // ====================

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        bram_tdp bank_i (
            .clk_i (clk_i),
            .rst_i (rst_i),
            .port  (bank_if[k])
        );

        // Port A to the low lanes, port B to the high lanes
        assign bank_data_o[k]           = bank_if[k].dout_a;
        assign bank_data_o[NUM_BANKS+k] = bank_if[k].dout_b;
    end

endmodule : bram_chain

`default_nettype wire

// File: verification/bram_chain_sva.sv
/*
 * Memory bank chain assertions
 * Bound to the top level, checks lane data and controller register rules
 */
`timescale 1ns/1ns
`default_nettype none

module bram_chain_sva #(
    parameter int NUM_BANKS = 8
) (
    input wire logic                                                clk_i,
    input wire logic                                                rst_i,
    input wire logic                                                load_en_i,
    input wire logic                                                chain_en_i,
    input wire logic                                                write_en_i,
    input wire bram_chain_types_pkg::data_word_t [2*NUM_BANKS-1:0]  bank_data_o
);

    // Mode as the controller sees it
    bram_chain_types_pkg::bank_mode_e mode_s;

    always_comb begin
        if (load_en_i) begin
            mode_s = bram_chain_types_pkg::MODE_LOAD;
        end else if (chain_en_i || write_en_i) begin
            mode_s = bram_chain_types_pkg::MODE_EXEC;
        end else begin
            mode_s = bram_chain_types_pkg::MODE_IDLE;
        end
    end

    a_lanes_known: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(bank_data_o))
        else $error("bank_data_o holds unknown bits");

    // ====================
    // Per-bank rules
    // ====================

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        a_load_addr_eq: assert property (@(posedge clk_i) disable iff (rst_i)
            mode_s == bram_chain_types_pkg::MODE_LOAD |=>
            (bank_if[k].raddr_a == bank_if[k].waddr_a) &&
            (bank_if[k].raddr_b == bank_if[k].waddr_b))
            else $error("read and write addresses differ after a load");

        // No load, no write, so the data registers park
        a_din_zero: assert property (@(posedge clk_i) disable iff (rst_i)
            (mode_s != bram_chain_types_pkg::MODE_LOAD) && !write_en_i |=>
            (bank_if[k].din_a == '0) && (bank_if[k].din_b == '0))
            else $error("write data not zero without a load or write");
    end

endmodule : bram_chain_sva

bind bram_chain bram_chain_sva #(.NUM_BANKS(NUM_BANKS)) sva_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .load_en_i   (load_en_i),
    .chain_en_i  (chain_en_i),
    .write_en_i  (write_en_i),
    .bank_data_o (bank_data_o)
);

`default_nettype wire

// File: verification/bram_chain_tb.sv
/*
 * Memory bank chain testbench
 * Table of load, chain and write rows applied in a loop against a reference model
 */
`timescale 1ns/1ns
`default_nettype none

module bram_chain_tb;

    localparam int NB       = bram_chain_cfg_pkg::NUM_BANKS_DEF;
    localparam int WBD      = bram_chain_cfg_pkg::WB_DELAY_DEF;
    localparam int LANES    = 2 * NB;
    localparam int DEPTH    = bram_chain_cfg_pkg::BANK_DEPTH;
    localparam int MAX_ROWS = 96;

    typedef bram_chain_types_pkg::data_word_t [LANES-1:0] data_lanes_t;
    typedef bram_chain_types_pkg::addr_word_t [LANES-1:0] addr_lanes_t;

    // One table row, exp is filled in by the model one row later
    typedef struct {
        logic                             load;
        logic                             chain;
        logic                             write;
        logic [NB-1:0]                    we;
        bram_chain_types_pkg::data_word_t lda;
        bram_chain_types_pkg::data_word_t ldb;
        bram_chain_types_pkg::addr_word_t laa;
        bram_chain_types_pkg::addr_word_t lab;
        addr_lanes_t                      gen;
        data_lanes_t                      wbd;
        logic                             chk;
        data_lanes_t                      exp;
    } row_t;

    logic                             clk_i;
    logic                             rst_i;
    logic                             load_en_i;
    logic                             chain_en_i;
    logic                             write_en_i;
    logic [NB-1:0]                    bank_we_i;
    bram_chain_types_pkg::data_word_t load_data_a_i;
    bram_chain_types_pkg::data_word_t load_data_b_i;
    bram_chain_types_pkg::addr_word_t load_addr_a_i;
    bram_chain_types_pkg::addr_word_t load_addr_b_i;
    addr_lanes_t                      gen_addr_i;
    data_lanes_t                      wb_data_i;
    data_lanes_t                      bank_data_o;

    row_t rows [MAX_ROWS];
    int   n_rows;
    int   n_checks;
    int   n_errors;
    logic table_ready;

    // ====================
    // Reference model state
    // ====================

    bram_chain_types_pkg::data_word_t m_mem [NB][DEPTH];
    addr_lanes_t                      m_raddr;
    addr_lanes_t                      m_waddr;
    data_lanes_t                      m_din;
    // Front is the oldest read, as seen by the write-back path
    addr_lanes_t                      m_delay [$];

    bram_chain dut_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .load_en_i     (load_en_i),
        .chain_en_i    (chain_en_i),
        .write_en_i    (write_en_i),
        .bank_we_i     (bank_we_i),
        .load_data_a_i (load_data_a_i),
        .load_data_b_i (load_data_b_i),
        .load_addr_a_i (load_addr_a_i),
        .load_addr_b_i (load_addr_b_i),
        .gen_addr_i    (gen_addr_i),
        .wb_data_i     (wb_data_i),
        .bank_data_o   (bank_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Per-lane address ramp, distinct lanes within a bank
    function automatic addr_lanes_t ramp_addr(input int base, input int step);
        addr_lanes_t a;
        for (int l = 0; l < LANES; l++) begin
            a[l] = bram_chain_types_pkg::addr_word_t'((base + step * l) % DEPTH);
        end
        return a;
    endfunction

    // A address on low lanes, B address on high lanes
    function automatic addr_lanes_t split_addr(input int a, input int b);
        addr_lanes_t r;
        for (int l = 0; l < LANES; l++) begin
            r[l] = bram_chain_types_pkg::addr_word_t'((l < NB) ? a : b);
        end
        return r;
    endfunction

    function automatic data_lanes_t random_lanes();
        data_lanes_t d;
        for (int l = 0; l < LANES; l++) begin
            d[l] = bram_chain_types_pkg::data_word_t'($urandom);
        end
        return d;
    endfunction

    // Append one row and step the model through the edge that samples it
    task automatic add_row(input logic load, input logic chain, input logic write,
                           input logic [NB-1:0] we,
                           input bram_chain_types_pkg::data_word_t lda,
                           input bram_chain_types_pkg::data_word_t ldb,
                           input bram_chain_types_pkg::addr_word_t laa,
                           input bram_chain_types_pkg::addr_word_t lab,
                           input addr_lanes_t gen, input data_lanes_t wbd, input logic chk);
        addr_lanes_t wb;
        // Read-first, dout of this edge answers the previous row
        if (n_rows > 0) begin
            for (int l = 0; l < LANES; l++) begin
                rows[n_rows-1].exp[l] = m_mem[l % NB][m_raddr[l]];
            end
        end
        // Port A then port B
        for (int k = 0; k < NB; k++) begin
            if (we[k]) begin
                m_mem[k][m_waddr[k]]    = m_din[k];
                m_mem[k][m_waddr[NB+k]] = m_din[NB+k];
            end
        end
        wb = m_delay[0];
        if (load) begin
            for (int k = 0; k < NB; k++) begin
                m_raddr[k]    = laa;
                m_waddr[k]    = laa;
                m_din[k]      = lda;
                m_raddr[NB+k] = lab;
                m_waddr[NB+k] = lab;
                m_din[NB+k]   = ldb;
            end
        end else begin
            m_din = '0;
            if (chain) begin
                m_raddr = gen;
            end
            if (write) begin
                m_waddr = wb;
                m_din   = wbd;
            end
        end
        // Delay line counts strobes, load cycles too
        if (chain) begin
            void'(m_delay.pop_front());
            m_delay.push_back(gen);
        end
        rows[n_rows] = '{load, chain, write, we, lda, ldb, laa, lab, gen, wbd, chk, '0};
        n_rows++;
    endtask

    task automatic push_load(input int laa, input int lab, input logic chain,
                             input addr_lanes_t gen);
        add_row(1'b1, chain, 1'b0, '0,
                bram_chain_types_pkg::data_word_t'($urandom),
                bram_chain_types_pkg::data_word_t'($urandom),
                bram_chain_types_pkg::addr_word_t'(laa),
                bram_chain_types_pkg::addr_word_t'(lab), gen, '0, 1'b1);
    endtask

    task automatic push_exec(input logic chain, input logic write, input logic [NB-1:0] we,
                             input addr_lanes_t gen, input data_lanes_t wbd, input logic chk);
        add_row(1'b0, chain, write, we, '0, '0, '0, '0, gen, wbd, chk);
    endtask

    // ====================
    // Stimulus table
    // ====================

    task automatic build_table();
        for (int i = 0; i < WBD; i++) begin
            m_delay.push_back('0);
        end
        // Load broadcast, load row itself reads old word at the write edge
        push_load(3, 17, 1'b0, '0);
        push_exec(1'b1, 1'b0, '1, split_addr(3, 17), '0, 1'b1);
        // Only banks 0 to 3 take the new words
        push_load(3, 17, 1'b0, '0);
        push_exec(1'b1, 1'b0, 8'h0f, split_addr(3, 17), '0, 1'b1);
        // Write-back lands at the address read WB_DELAY strobes earlier
        for (int s = 0; s < WBD; s++) begin
            push_exec(1'b1, 1'b0, '0, ramp_addr(1 + 4 * s, 1), '0, 1'b1);
        end
        push_exec(1'b0, 1'b1, '0, '0, random_lanes(), 1'b0);
        push_exec(1'b1, 1'b0, '1, ramp_addr(1, 1), '0, 1'b1);
        push_exec(1'b1, 1'b0, '0, ramp_addr(5, 1), '0, 1'b1);
        // Same again with idle gaps between strobes
        for (int s = 0; s < WBD; s++) begin
            push_exec(1'b1, 1'b0, '0, ramp_addr(20 + 3 * s, 3), '0, 1'b1);
            for (int g = 0; g < s % 3; g++) begin
                push_exec(1'b0, 1'b0, '0, '0, '0, 1'b0);
            end
        end
        push_exec(1'b0, 1'b1, '0, '0, random_lanes(), 1'b0);
        push_exec(1'b1, 1'b0, '1, ramp_addr(20, 3), '0, 1'b1);
        // Load with a chain strobe in the same row acts as a load
        push_load(11, 12, 1'b1, ramp_addr(0, 1));
        push_exec(1'b1, 1'b0, '1, split_addr(11, 12), '0, 1'b1);
        // Both ports write address 9, B word must remain
        push_load(9, 9, 1'b0, '0);
        push_exec(1'b1, 1'b0, '1, split_addr(9, 9), '0, 1'b1);
        push_exec(1'b0, 1'b0, '0, '0, '0, 1'b0);
        push_exec(1'b0, 1'b0, '0, '0, '0, 1'b0);
    endtask

    // ====================
    // Checks
    // ====================

    task automatic check_word(input string name, input int idx,
                              input bram_chain_types_pkg::data_word_t got,
                              input bram_chain_types_pkg::data_word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %s[%0d] got 0x%h expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic check_lanes(input string name, input data_lanes_t got,
                               input data_lanes_t exp);
        for (int l = 0; l < LANES; l++) begin
            check_word(name, l, got[l], exp[l]);
        end
    endtask

    task automatic drive_row(input int j);
        load_en_i     = rows[j].load;
        chain_en_i    = rows[j].chain;
        write_en_i    = rows[j].write;
        bank_we_i     = rows[j].we;
        load_data_a_i = rows[j].lda;
        load_data_b_i = rows[j].ldb;
        load_addr_a_i = rows[j].laa;
        load_addr_b_i = rows[j].lab;
        gen_addr_i    = rows[j].gen;
        wb_data_i     = rows[j].wbd;
    endtask

    task automatic drive_idle();
        load_en_i     = 1'b0;
        chain_en_i    = 1'b0;
        write_en_i    = 1'b0;
        bank_we_i     = '0;
        load_data_a_i = '0;
        load_data_b_i = '0;
        load_addr_a_i = '0;
        load_addr_b_i = '0;
        gen_addr_i    = '0;
        wb_data_i     = '0;
    endtask

    // Stops a stuck run
    initial begin
        wait (table_ready);
        #((n_rows + 20) * 100);
        $display("Timeout: the table did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'hacb829e2));
        n_rows      = 0;
        n_checks    = 0;
        n_errors    = 0;
        table_ready = 1'b0;
        m_raddr     = '0;
        m_waddr     = '0;
        m_din       = '0;
        for (int k = 0; k < NB; k++) begin
            for (int a = 0; a < DEPTH; a++) begin
                m_mem[k][a] = '0;
            end
        end
        rst_i = 1'b1;
        drive_idle();
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk_i);
        #5 rst_i = 1'b0;
        check_lanes("bank_data_o", bank_data_o, '0);
        // Row j-2 is answered after edge j
        for (int j = 0; j < n_rows + 2; j++) begin
            @(posedge clk_i);
            #5;
            if (j >= 2 && rows[j-2].chk) begin
                check_lanes("bank_data_o", bank_data_o, rows[j-2].exp);
            end
            if (j < n_rows) begin
                drive_row(j);
            end else begin
                drive_idle();
            end
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : bram_chain_tb

`default_nettype wire

// File: sources.f
src/bram_chain_cfg_pkg.sv
src/bram_chain_types_pkg.sv
src/bank_port_if.sv
src/bram_tdp.sv
src/writeback_addr_delay.sv
src/bank_port_ctrl.sv
src/bram_chain.sv
verification/bram_chain_sva.sv
verification/bram_chain_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory bank chain simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module bram_chain_tb \
    -o bram_chain_sim

# The log decides pass or fail, so a failing run still reaches the search
./obj_dir/bram_chain_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
